/* files.f */
src/pcs_pkg.sv
src/gx_pkg.sv
src/gx_reset_seq.sv
src/pcs_rx_decode.sv
src/pcs_loopback.sv
src/pcs_tx_encode.sv
src/top_pcs.sv
bench/top_pcs_properties.sv
bench/tb_top_pcs.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the top_pcs testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_top_pcs -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/Vtb_top_pcs > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* bench/tb_top_pcs.sv */
// testbench for top_pcs driving random pcs blocks and lock levels and checking against a model
module tb_top_pcs;
	timeunit 1ns;
	timeprecision 100ps;
	import pcs_pkg::*;
	import gx_pkg::*;

	localparam int PD_N = 4;
	localparam int SET_N = 3;
	localparam int RUN_CYCLES = 376; // sum of all run_cycles calls below
	localparam int READY_WAIT_MAX = 40; // longest reset sequence in cycles
	localparam longint TIMEOUT_NS = 64'(RUN_CYCLES + 3 * READY_WAIT_MAX + 3 + 8) * 40;
	localparam pcs_block_t EXP_IDLE = '{hdr: 2'b10, payload: {56'h0, 8'h1e}};
	localparam pcs_block_t EXP_ERR = '{hdr: 2'b10, payload: {{8{7'h1e}}, 8'h1e}};

	logic clk_50m = 1'b0;
	logic reset_i;
	logic pll_locked_i;
	logic tx_cal_busy_i;
	logic rx_cal_busy_i;
	logic rx_is_lockedtodata_i;
	pcs_block_t rx_par_data_i;
	gx_rst_t gx_rst_o;
	logic tx_ready_o;
	logic rx_ready_o;
	pcs_block_t tx_par_data_o;

	integer seed = 32'h3a1a;
	logic gen_in_frame = 1'b0; // keeps generated traffic mostly well formed
	int gen_term_len = 0; // well formed terminates step through every length
	// model: kinds are 0 data, 1 idle, 2 start, 3 term, 4 err
	int m_st;
	int m_cnt;
	int m_k1;
	int m_k2;
	logic m_frame;
	pcs_block_t m_b1;
	pcs_block_t m_b2;
	pcs_block_t m_s3;

	top_pcs #(.PLL_PD_CYCLES(PD_N), .SETTLE_CYCLES(SET_N)) dut0 (.*);

	always #10 clk_50m = ~clk_50m;

	initial begin
		#(TIMEOUT_NS);
		$display("timeout: the test sequence did not finish in time");
		$display("TB FAILED");
		$fatal(1);
	end

	function automatic logic [7:0] term_type(input int k);
		logic [7:0] tbl [8] = '{8'h87, 8'h99, 8'haa, 8'hb4, 8'hcc, 8'hd2, 8'he1, 8'hff};
		return tbl[k];
	endfunction

	function automatic int classify(input pcs_block_t b);
		logic [55:0] tail;
		tail = b.payload[63:8];
		if (b.hdr == 2'b01)
			return 0;
		if (b.hdr != 2'b10)
			return 4;
		if (b.payload[7:0] == 8'h1e && tail == 56'h0)
			return 1;
		if (b.payload[7:0] == 8'h78)
			return 2;
		for (int k = 0; k < 8; k++)
			if (b.payload[7:0] == term_type(k))
				return ((tail >> (8 * k)) == 56'h0) ? 3 : 4; // trailing bytes must be idle codes
		return 4;
	endfunction

	// reference model, pipeline first since loopback sees the old link level
	always @(posedge clk_50m) begin
		int nst;
		logic en;
		logic link;
		if (reset_i) begin
			m_st = 0;
			m_cnt = 0;
			m_frame = 1'b0;
			m_k1 = 1;
			m_k2 = 1;
			m_b1 = EXP_IDLE;
			m_b2 = EXP_IDLE;
			m_s3 = EXP_IDLE;
		end else begin
			link = (m_st == 6);
			m_s3 = (m_k2 == 4) ? EXP_ERR : (m_k2 == 1) ? EXP_IDLE : m_b2;
			m_k2 = m_k1;
			m_b2 = m_b1;
			if (!link) begin
				m_k2 = 1;
				m_frame = 1'b0;
			end else if (m_k1 == 4) begin
				m_frame = 1'b0;
			end else if (m_frame) begin
				if (m_k1 == 1 || m_k1 == 2) begin
					m_k2 = 4;
					m_frame = 1'b0;
				end else if (m_k1 == 3)
					m_frame = 1'b0;
			end else if (m_k1 == 2)
				m_frame = 1'b1;
			else if (m_k1 == 0 || m_k1 == 3)
				m_k2 = 4; // no frame open
			m_k1 = classify(rx_par_data_i);
			m_b1 = rx_par_data_i;
			nst = m_st;
			en = 1'b0;
			case (m_st)
				0: begin
					en = 1'b1;
					if (m_cnt == PD_N - 1) nst = 1;
				end
				1: begin
					en = pll_locked_i & ~tx_cal_busy_i;
					if (en && m_cnt == SET_N - 1) nst = 2;
				end
				2: nst = 3;
				3: begin
					en = ~rx_cal_busy_i;
					if (en && m_cnt == SET_N - 1) nst = 4;
				end
				4: begin
					en = rx_is_lockedtodata_i & ~rx_cal_busy_i;
					if (en && m_cnt == SET_N - 1) nst = 5;
				end
				5: nst = rx_is_lockedtodata_i ? 6 : 3;
				default: if (!rx_is_lockedtodata_i) nst = 3;
			endcase
			if (m_st >= 2 && !pll_locked_i)
				nst = 0;
			m_cnt = (nst != m_st || !en) ? 0 : m_cnt + 1;
			m_st = nst;
		end
	end

	task automatic check_block(input string name, input pcs_block_t got, input pcs_block_t exp);
		if (got !== exp) begin
			$display("FAILED %s exp=%h got=%h", name, exp, got);
			$display("TB FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_rst(input string name, input gx_rst_t got, input gx_rst_t exp);
		if (got !== exp) begin
			$display("FAILED %s exp=%h got=%h", name, exp, got);
			$display("TB FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_ready(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED %s exp=%h got=%h", name, exp, got);
			$display("TB FAILED");
			$fatal(1);
		end
	endtask

	task automatic compare_outputs();
		gx_rst_t exp_rst;
		exp_rst = '{pll_powerdown: m_st == 0, tx_analogreset: m_st <= 1,
			tx_digitalreset: m_st <= 1, rx_analogreset: m_st <= 3, rx_digitalreset: m_st <= 4};
		check_rst("gx_rst_o", gx_rst_o, exp_rst);
		check_ready("tx_ready_o", tx_ready_o, m_st >= 2);
		check_ready("rx_ready_o", rx_ready_o, m_st == 6);
		check_block("tx_par_data_o", tx_par_data_o, m_s3);
		if (dut0.u_props.fail_cnt != 0) begin
			$display("a concurrent assertion on the reset outputs or ready levels failed");
			$display("TB FAILED");
			$fatal(1);
		end
	endtask

	function automatic pcs_block_t random_block();
		logic [63:0] rnd;
		logic [55:0] mask;
		int k;
		rnd = {$random(seed), $random(seed)};
		k = $unsigned($random(seed)) % 8;
		mask = (56'h1 << (8 * k)) - 56'h1;
		if ($unsigned($random(seed)) % 8 == 0) begin
			case ($unsigned($random(seed)) % 4)
				0: return '{hdr: rnd[0] ? 2'b11 : 2'b00, payload: rnd}; // bad header
				1: return '{hdr: 2'b10, payload: {rnd[63:8], 8'h55}};   // unknown type
				2: begin
					// start or idle inside a frame, term or data outside one
					if (gen_in_frame && rnd[1])
						return '{hdr: 2'b10, payload: {rnd[63:8], 8'h78}};
					if (gen_in_frame)
						return EXP_IDLE;
					if (rnd[1])
						return '{hdr: 2'b10, payload: {rnd[63:8] & mask, term_type(k)}};
					return '{hdr: 2'b01, payload: rnd};
				end
				default: return '{hdr: 2'b10, payload: {rnd[63:8] | 56'h1, 8'h1e}};
			endcase
		end
		if (!gen_in_frame) begin
			if (rnd[0])
				return EXP_IDLE;
			gen_in_frame = 1'b1;
			return '{hdr: 2'b10, payload: {rnd[63:8], 8'h78}};
		end
		if (rnd[2:1] == 2'b00) begin
			gen_in_frame = 1'b0;
			k = gen_term_len;
			mask = (56'h1 << (8 * k)) - 56'h1;
			gen_term_len = (gen_term_len + 1) % 8;
			return '{hdr: 2'b10, payload: {rnd[63:8] & mask, term_type(k)}};
		end
		return '{hdr: 2'b01, payload: rnd};
	endfunction

	task automatic run_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			@(negedge clk_50m);
			compare_outputs();
			rx_par_data_i = random_block();
		end
	endtask

	// keeps traffic and checks running until the reset sequence completes
	task automatic wait_rx_ready(input int max_n);
		int n;
		n = 0;
		while (rx_ready_o !== 1'b1) begin
			if (n == max_n) begin
				$display("rx_ready_o did not rise within %0d cycles", max_n);
				$display("TB FAILED");
				$fatal(1);
			end
			run_cycles(1);
			n++;
		end
	endtask

	initial begin
		reset_i = 1'b1;
		pll_locked_i = 1'b1;
		tx_cal_busy_i = 1'b1;
		rx_cal_busy_i = 1'b0;
		rx_is_lockedtodata_i = 1'b1;
		rx_par_data_i = EXP_IDLE;
		repeat (3) @(posedge clk_50m);
		@(negedge clk_50m);
		check_rst("gx_rst_o", gx_rst_o, 5'b11111);
		check_ready("tx_ready_o", tx_ready_o, 1'b0);
		check_ready("rx_ready_o", rx_ready_o, 1'b0);
		check_block("tx_par_data_o", tx_par_data_o, EXP_IDLE);
		reset_i = 1'b0;
		run_cycles(8);
		tx_cal_busy_i = 1'b0; // tx calibration ends during the lock wait
		wait_rx_ready(READY_WAIT_MAX);
		run_cycles(160);
		rx_is_lockedtodata_i = 1'b0;
		run_cycles(10);
		rx_is_lockedtodata_i = 1'b1;
		wait_rx_ready(READY_WAIT_MAX);
		run_cycles(50);
		rx_cal_busy_i = 1'b1;
		pll_locked_i = 1'b0;
		run_cycles(6);
		pll_locked_i = 1'b1;
		run_cycles(12);
		rx_cal_busy_i = 1'b0;
		wait_rx_ready(READY_WAIT_MAX);
		run_cycles(130);
		$display("TB PASSED");
		$finish;
	end

endmodule

/* bench/top_pcs_properties.sv */
// concurrent checks on reset lines and ready levels, bound into every top_pcs instance
module top_pcs_properties (
	input logic            clk_50m,
	input logic            reset_i,
	input gx_pkg::gx_rst_t gx_rst_o,
	input logic            tx_ready_o,
	input logic            rx_ready_o
);
	timeunit 1ns;
	timeprecision 100ps;

	int unsigned fail_cnt = 0; // failed assertion count

	rx_implies_tx: assert property (@(posedge clk_50m) disable iff (reset_i)
		rx_ready_o |-> tx_ready_o)
		else begin
			$error("rx ready without tx ready");
			fail_cnt++;
		end

	tx_ready_no_tx_rst: assert property (@(posedge clk_50m) disable iff (reset_i)
		tx_ready_o |-> !(gx_rst_o.tx_analogreset || gx_rst_o.tx_digitalreset))
		else begin
			$error("tx reset held while tx ready");
			fail_cnt++;
		end

	rx_ready_no_rst: assert property (@(posedge clk_50m) disable iff (reset_i)
		rx_ready_o |-> (gx_rst_o == '0))
		else begin
			$error("reset line held while rx ready");
			fail_cnt++;
		end

	pd_not_ready: assert property (@(posedge clk_50m) disable iff (reset_i)
		gx_rst_o.pll_powerdown |-> (!tx_ready_o && !rx_ready_o))
		else begin
			$error("ready level high during pll power down");
			fail_cnt++;
		end

endmodule

bind top_pcs top_pcs_properties u_props (
	.clk_50m   (clk_50m),
	.reset_i   (reset_i),
	.gx_rst_o  (gx_rst_o),
	.tx_ready_o(tx_ready_o),
	.rx_ready_o(rx_ready_o)
);

/* src/top_pcs.sv */
// single-lane pcs loopback top joining the transceiver reset sequencer and the block data path
module top_pcs #(
	parameter int PLL_PD_CYCLES = 8,
	parameter int SETTLE_CYCLES = 4
)(
	input  logic                clk_50m,
	input  logic                reset_i,
	input  logic                pll_locked_i,
	input  logic                tx_cal_busy_i,
	input  logic                rx_cal_busy_i,
	input  logic                rx_is_lockedtodata_i,
	input  pcs_pkg::pcs_block_t rx_par_data_i,
	output gx_pkg::gx_rst_t     gx_rst_o,
	output logic                tx_ready_o,
	output logic                rx_ready_o,
	output pcs_pkg::pcs_block_t tx_par_data_o
);
	import pcs_pkg::*;

	logic      link_ready; // tx and rx both out of reset
	pcs_word_t rx_word;
	pcs_word_t tx_word;

	gx_reset_seq #(
		.PLL_PD_CYCLES(PLL_PD_CYCLES),
		.SETTLE_CYCLES(SETTLE_CYCLES)
	) m_gx_reset_seq (
		.clk_50m             (clk_50m),
		.reset_i             (reset_i),
		.pll_locked_i        (pll_locked_i),
		.tx_cal_busy_i       (tx_cal_busy_i),
		.rx_cal_busy_i       (rx_cal_busy_i),
		.rx_is_lockedtodata_i(rx_is_lockedtodata_i),
		.gx_rst_o            (gx_rst_o),
		.tx_ready_o          (tx_ready_o),
		.rx_ready_o          (rx_ready_o),
		.link_ready_o        (link_ready)
	);

	pcs_rx_decode m_pcs_rx_decode (
		.clk_50m   (clk_50m),
		.reset_i   (reset_i),
		.rx_block_i(rx_par_data_i),
		.rx_word_o (rx_word)
	);

	pcs_loopback m_pcs_loopback (
		.clk_50m     (clk_50m),
		.reset_i     (reset_i),
		.link_ready_i(link_ready),
		.rx_word_i   (rx_word),
		.tx_word_o   (tx_word)
	);

	pcs_tx_encode m_pcs_tx_encode (
		.clk_50m   (clk_50m),
		.reset_i   (reset_i),
		.tx_word_i (tx_word),
		.tx_block_o(tx_par_data_o)
	);

endmodule

/* src/pcs_tx_encode.sv */
// transmit block encoder rebuilding registered 66-bit blocks from pcs words, used by top_pcs
module pcs_tx_encode (
	input  logic                clk_50m,
	input  logic                reset_i,
	input  pcs_pkg::pcs_word_t  tx_word_i,
	output pcs_pkg::pcs_block_t tx_block_o
);
	import pcs_pkg::*;

	logic [3:0]  term_len;
	logic [55:0] term_tail;
	pcs_block_t  block_d;

	// keep is contiguous from byte 0, so its weight is the terminate position
	always_comb begin
		term_len  = 4'($countones(tx_word_i.keep));
		term_tail = '0;
		for (int i = 0; i < 7; i++) begin
			if (tx_word_i.keep[i])
				term_tail[8*i +: 8] = tx_word_i.data[8*i +: 8];
			else
				term_tail[8*i +: 8] = {1'b0, IDLE_CODE};
		end
	end

	always_comb begin
		block_d = ERR_BLOCK; // err and unknown control words
		if (!tx_word_i.ctrl) begin
			block_d.hdr     = HDR_DATA;
			block_d.payload = tx_word_i.data;
		end else if (tx_word_i.err) begin
			block_d = ERR_BLOCK;
		end else if (tx_word_i.idle) begin
			block_d = IDLE_BLOCK;
		end else if (tx_word_i.start) begin
			block_d.hdr     = HDR_CTRL;
			block_d.payload = {tx_word_i.data[63:8], BT_START};
		end else if (tx_word_i.term) begin
			block_d.hdr     = HDR_CTRL;
			block_d.payload = {term_tail, term_btype(term_len)};
		end
	end

	always_ff @(posedge clk_50m) begin
		if (reset_i)
			tx_block_o <= IDLE_BLOCK;
		else
			tx_block_o <= block_d;
	end

endmodule

/* src/pcs_loopback.sv */
// loopback stage forwarding rx words to tx with frame order checks, used by top_pcs
module pcs_loopback (
	input  logic               clk_50m,
	input  logic               reset_i,
	input  logic               link_ready_i,
	input  pcs_pkg::pcs_word_t rx_word_i,
	output pcs_pkg::pcs_word_t tx_word_o
);
	import pcs_pkg::*;

	typedef enum logic {
		FR_IDLE,
		FR_IN_FRAME
	} frame_state_e;

	frame_state_e frame_q;
	frame_state_e frame_d;
	pcs_word_t    word_d;

	always_comb begin
		word_d  = rx_word_i;
		frame_d = frame_q;
		if (!link_ready_i) begin
			word_d  = IDLE_WORD; // input discarded while the link is down
			frame_d = FR_IDLE;
		end else if (rx_word_i.err) begin
			frame_d = FR_IDLE; // error aborts any open frame
		end else if (frame_q == FR_IN_FRAME) begin
			if (rx_word_i.start || rx_word_i.idle) begin
				word_d  = ERR_WORD;
				frame_d = FR_IDLE;
			end else if (rx_word_i.term) begin
				frame_d = FR_IDLE;
			end
		end else begin
			if (rx_word_i.start)
				frame_d = FR_IN_FRAME;
			else if (rx_word_i.term || !rx_word_i.ctrl)
				word_d = ERR_WORD; // term or data with no frame open
		end
	end

	always_ff @(posedge clk_50m) begin
		if (reset_i) begin
			frame_q   <= FR_IDLE;
			tx_word_o <= IDLE_WORD;
		end else begin
			frame_q   <= frame_d;
			tx_word_o <= word_d;
		end
	end

endmodule

/* src/pcs_rx_decode.sv */
// receive block decoder turning each 66-bit block into a registered pcs word, used by top_pcs
module pcs_rx_decode (
	input  logic                clk_50m,
	input  logic                reset_i,
	input  pcs_pkg::pcs_block_t rx_block_i,
	output pcs_pkg::pcs_word_t  rx_word_o
);
	import pcs_pkg::*;

	logic [7:0]  btype;
	logic [55:0] tail;      // payload after the type byte
	logic        is_term;
	logic [2:0]  term_len;
	logic        trail_ok;  // bytes past the terminate are idle codes
	logic [55:0] term_data;
	logic [7:0]  term_keep;
	pcs_word_t   word_d;

	assign btype = rx_block_i.payload[7:0];
	assign tail  = rx_block_i.payload[63:8];

	// match the type byte against every terminate length
	always_comb begin
		is_term   = 1'b0;
		term_len  = 3'd0;
		trail_ok  = 1'b1;
		term_data = '0;
		for (int n = 0; n < 8; n++) begin
			if (btype == term_btype(4'(n))) begin
				is_term  = 1'b1;
				term_len = 3'(n);
			end
		end
		for (int i = 0; i < 7; i++) begin
			if (i < term_len)
				term_data[8*i +: 8] = tail[8*i +: 8];
			else if (tail[8*i +: 8] != {1'b0, IDLE_CODE})
				trail_ok = 1'b0;
		end
		term_keep = (8'h01 << term_len) - 8'h01;
	end

	always_comb begin
		word_d = ERR_WORD; // bad header, type or code
		if (rx_block_i.hdr == HDR_DATA) begin
			word_d      = '0;
			word_d.data = rx_block_i.payload;
			word_d.keep = 8'hff;
		end else if (rx_block_i.hdr == HDR_CTRL) begin
			if (btype == BT_IDLE && tail == {8{IDLE_CODE}}) begin
				word_d = IDLE_WORD;
			end else if (btype == BT_START) begin
				word_d       = '0;
				word_d.ctrl  = 1'b1;
				word_d.start = 1'b1;
				word_d.data  = {tail, 8'h00}; // lane 0 carries the start
				word_d.keep  = 8'hfe;
			end else if (is_term && trail_ok) begin
				word_d      = '0;
				word_d.ctrl = 1'b1;
				word_d.term = 1'b1;
				word_d.data = {8'h00, term_data};
				word_d.keep = term_keep;
			end
		end
	end

	always_ff @(posedge clk_50m) begin
		if (reset_i)
			rx_word_o <= IDLE_WORD;
		else
			rx_word_o <= word_d;
	end

endmodule

/* src/gx_reset_seq.sv */
// transceiver reset sequencer stepping pll, tx and rx resets in order, instantiated by top_pcs
module gx_reset_seq #(
	parameter int PLL_PD_CYCLES = 8,
	parameter int SETTLE_CYCLES = 4
)(
	input  logic            clk_50m,
	input  logic            reset_i,
	input  logic            pll_locked_i,
	input  logic            tx_cal_busy_i,
	input  logic            rx_cal_busy_i,
	input  logic            rx_is_lockedtodata_i,
	output gx_pkg::gx_rst_t gx_rst_o,
	output logic            tx_ready_o,
	output logic            rx_ready_o,
	output logic            link_ready_o
);
	import gx_pkg::*;

	localparam int CNT_MAX = (PLL_PD_CYCLES > SETTLE_CYCLES) ? PLL_PD_CYCLES : SETTLE_CYCLES;
	localparam int CNT_W = $clog2(CNT_MAX + 1);
	localparam logic [CNT_W-1:0] PD_LAST     = CNT_W'(PLL_PD_CYCLES - 1);
	localparam logic [CNT_W-1:0] SETTLE_LAST = CNT_W'(SETTLE_CYCLES - 1);

	gx_rst_state_e    state_q;
	gx_rst_state_e    state_d;
	logic [CNT_W-1:0] cnt_q; // shared by power down and settle waits
	logic             cnt_en;
	logic             tx_ok;
	logic             rx_ok;
	logic             tx_held;

	assign tx_ok = pll_locked_i & ~tx_cal_busy_i;
	assign rx_ok = rx_is_lockedtodata_i & ~rx_cal_busy_i;

	always_comb begin
		state_d = state_q;
		cnt_en  = 1'b0;
		case (state_q)
			ST_PLL_PD: begin
				cnt_en = 1'b1;
				if (cnt_q == PD_LAST)
					state_d = ST_WAIT_PLL;
			end
			ST_WAIT_PLL: begin
				cnt_en = tx_ok; // restart the settle time on any glitch
				if (tx_ok && cnt_q == SETTLE_LAST)
					state_d = ST_TX_RELEASE;
			end
			ST_TX_RELEASE:
				state_d = ST_WAIT_RXLOCK;
			ST_WAIT_RXLOCK: begin
				cnt_en = ~rx_cal_busy_i;
				if (!rx_cal_busy_i && cnt_q == SETTLE_LAST)
					state_d = ST_RX_ANA_RELEASE;
			end
			ST_RX_ANA_RELEASE: begin
				cnt_en = rx_ok;
				if (rx_ok && cnt_q == SETTLE_LAST)
					state_d = ST_RX_DIG_RELEASE;
			end
			ST_RX_DIG_RELEASE:
				state_d = rx_is_lockedtodata_i ? ST_READY : ST_WAIT_RXLOCK;
			ST_READY:
				if (!rx_is_lockedtodata_i)
					state_d = ST_WAIT_RXLOCK;
			default:
				state_d = ST_PLL_PD;
		endcase

		// pll loss wins over everything once tx is out of reset
		if (!tx_held && !pll_locked_i)
			state_d = ST_PLL_PD;
	end

	always_ff @(posedge clk_50m) begin
		if (reset_i) begin
			state_q <= ST_PLL_PD;
			cnt_q   <= '0;
		end else begin
			state_q <= state_d;
			cnt_q   <= (state_d != state_q || !cnt_en) ? '0 : cnt_q + 1'b1;
		end
	end

	assign tx_held = (state_q == ST_PLL_PD) || (state_q == ST_WAIT_PLL);

	always_comb begin
		gx_rst_o.pll_powerdown   = (state_q == ST_PLL_PD);
		gx_rst_o.tx_analogreset  = tx_held;
		gx_rst_o.tx_digitalreset = tx_held;
		gx_rst_o.rx_analogreset  = tx_held || (state_q == ST_TX_RELEASE)
			|| (state_q == ST_WAIT_RXLOCK);
		gx_rst_o.rx_digitalreset = (state_q != ST_RX_DIG_RELEASE) && (state_q != ST_READY);
	end

	assign tx_ready_o   = ~tx_held;
	assign rx_ready_o   = (state_q == ST_READY);
	assign link_ready_o = tx_ready_o & rx_ready_o;

endmodule

/* src/gx_pkg.sv */
// transceiver reset control bundle and reset sequencer states, imported by the reset logic
package gx_pkg;

	// one bit per reset line of the transceiver, all active high
	typedef struct packed {
		logic pll_powerdown;
		logic tx_analogreset;
		logic tx_digitalreset;
		logic rx_analogreset;
		logic rx_digitalreset;
	} gx_rst_t;

	// sequencer walks these in order, lock loss jumps back
	typedef enum logic [2:0] {
		ST_PLL_PD,         // pll held in power down for a fixed time
		ST_WAIT_PLL,       // waiting for pll lock and tx calibration
		ST_TX_RELEASE,     // tx resets just released
		ST_WAIT_RXLOCK,    // rx resets held until rx calibration settles
		ST_RX_ANA_RELEASE, // rx analog released, waiting for cdr lock
		ST_RX_DIG_RELEASE, // rx digital just released
		ST_READY
	} gx_rst_state_e;

endpackage

/* src/pcs_pkg.sv */
// 66-bit block and decoded word types for the PCS data path, imported by the decode, loopback and encode stages
package pcs_pkg;

	typedef enum logic [1:0] {
		HDR_DATA = 2'b01,
		HDR_CTRL = 2'b10
	} pcs_hdr_e;

	// control block types, the terminate digit is the data byte count before it
	typedef enum logic [7:0] {
		BT_IDLE  = 8'h1e, // idle and error blocks share this type
		BT_START = 8'h78,
		BT_TERM0 = 8'h87,
		BT_TERM1 = 8'h99,
		BT_TERM2 = 8'haa,
		BT_TERM3 = 8'hb4,
		BT_TERM4 = 8'hcc,
		BT_TERM5 = 8'hd2,
		BT_TERM6 = 8'he1,
		BT_TERM7 = 8'hff
	} pcs_btype_e;

	typedef struct packed {
		logic [1:0]  hdr;     // raw sync header, may hold an invalid value
		logic [63:0] payload; // byte 0 is the block type in a control block
	} pcs_block_t;

	typedef struct packed {
		logic        ctrl;
		logic        idle;
		logic        start;
		logic        term;
		logic        err;
		logic [63:0] data; // byte 0 first
		logic [7:0]  keep;
	} pcs_word_t;

	localparam logic [6:0] IDLE_CODE = 7'h00;
	localparam logic [6:0] ERR_CODE  = 7'h1e;

	localparam pcs_word_t IDLE_WORD = '{ctrl: 1'b1, idle: 1'b1, start: 1'b0, term: 1'b0,
		err: 1'b0, data: 64'h0, keep: 8'h00};
	localparam pcs_word_t ERR_WORD = '{ctrl: 1'b1, idle: 1'b0, start: 1'b0, term: 1'b0,
		err: 1'b1, data: 64'h0, keep: 8'h00};

	localparam pcs_block_t IDLE_BLOCK = '{hdr: HDR_CTRL, payload: {{8{IDLE_CODE}}, BT_IDLE}};
	localparam pcs_block_t ERR_BLOCK  = '{hdr: HDR_CTRL, payload: {{8{ERR_CODE}}, BT_IDLE}};

	// terminate block type for a given number of leading data bytes
	function automatic pcs_btype_e term_btype(input logic [3:0] len);
		case (len)
			4'd0:    return BT_TERM0;
			4'd1:    return BT_TERM1;
			4'd2:    return BT_TERM2;
			4'd3:    return BT_TERM3;
			4'd4:    return BT_TERM4;
			4'd5:    return BT_TERM5;
			4'd6:    return BT_TERM6;
			default: return BT_TERM7;
		endcase
	endfunction

endpackage
